// ==== verilog/ptw_consts.svh ====
// --------------------
// sv39 walker constants
// address widths, pte layout and walk depth
// --------------------
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// virtual and physical address widths
`define PTW_VLEN 39
`define PTW_PLEN 56

// page number, asid and vpn widths
`define PTW_PPNW 44
`define PTW_ASIDW 16
`define PTW_VPNW 27

// one vpn slice per level, 4K page offset below them
`define PTW_VPN_SLICEW 9
`define PTW_PGOFFW 12
`define PTW_LEVELS 3

// pte word and its layout
`define PTW_XLEN 64
`define PTW_PTE_G 5
// log2 of the pte size in bytes
`define PTW_PTE_BYTES_LOG 3

`endif

// ==== verilog/ptw_pkg.sv ====
// --------------------
// sv39 walker types
// shared vectors, state enums and port structs
// --------------------
`default_nettype none

`include "ptw_consts.svh"

package ptw_pkg;

    typedef logic [`PTW_VLEN-1:0]  vaddr_t;
    typedef logic [`PTW_PLEN-1:0]  paddr_t;
    typedef logic [`PTW_PPNW-1:0]  ppn_t;
    typedef logic [`PTW_ASIDW-1:0] asid_t;
    typedef logic [`PTW_VPNW-1:0]  vpn_t;

    // sv39 page table entry, msb first
    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR,
        WAIT_RVALID
    } ptw_state_e;

    typedef enum logic [1:0] {
        PTE_FAULT,
        PTE_LEAF,
        PTE_POINTER
    } pte_verdict_e;

    typedef struct packed {
        logic  valid;
        vpn_t  vpn;
        asid_t asid;
        logic  is_2m;
        logic  is_1g;
        pte_t  content;
    } tlb_update_t;

    typedef struct packed {
        logic   req;
        paddr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic                 gnt;
        logic                 rvalid;
        logic [`PTW_XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/pte_check.sv ====
// --------------------
// sv39 pte checker
// registers the returned pte and classifies it as leaf, pointer or fault
// --------------------
`default_nettype none

`include "ptw_consts.svh"

module pte_check (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   mem_rvalid_i,
    input  logic [`PTW_XLEN-1:0]   mem_rdata_i,
    input  ptw_pkg::ptw_lvl_e      lvl_i,
    input  logic                   is_instr_i,
    input  logic                   is_store_i,
    input  logic                   mxr_i,
    output logic                   pte_valid_o,
    output ptw_pkg::pte_t          pte_o,
    output ptw_pkg::pte_verdict_e  verdict_o
);
    import ptw_pkg::*;

    localparam int unsigned SLICEW = `PTW_VPN_SLICEW;

    logic                 rvalid_q;
    logic [`PTW_XLEN-1:0] rdata_q;
    pte_t                 pte;
    logic                 is_leaf;
    logic                 perm_fault;
    logic                 misaligned;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign pte         = pte_t'(rdata_q);
    assign pte_o       = pte;
    assign pte_valid_o = rvalid_q;

    // --------------------
    // classification
    // --------------------
    always_comb begin
        is_leaf = pte.r || pte.x;

        // accessed bit is managed by software, so a clear one faults
        if (is_instr_i) begin
            perm_fault = !pte.a || !pte.x;
        end else begin
            // mxr lets an execute-only page be read
            perm_fault = !pte.a || !(pte.r || (pte.x && mxr_i)) ||
                         (is_store_i && !(pte.w && pte.d));
        end

        // superpage ppn must be aligned to its size
        unique case (lvl_i)
            LVL1:    misaligned = |pte.ppn[2*SLICEW-1:0];
            LVL2:    misaligned = |pte.ppn[SLICEW-1:0];
            default: misaligned = 1'b0;
        endcase

        if (!pte.v || (!pte.r && pte.w)) begin
            verdict_o = PTE_FAULT;
        end else if (!is_leaf) begin
            verdict_o = PTE_POINTER;
        end else if (perm_fault || misaligned) begin
            verdict_o = PTE_FAULT;
        end else begin
            verdict_o = PTE_LEAF;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_walk_state.sv ====
// --------------------
// walk state and pte addressing
// holds the vpn, asid and global bit of the walk, forms the
// next pte pointer and builds the tlb update
// --------------------
`default_nettype none

`include "ptw_consts.svh"

module ptw_walk_state (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 start_i,
    input  logic                 start_instr_i,
    input  logic                 descend_i,
    input  ptw_pkg::ptw_lvl_e    lvl_i,
    input  logic                 is_instr_i,
    input  logic                 update_valid_i,
    input  ptw_pkg::vaddr_t      itlb_vaddr_i,
    input  ptw_pkg::vaddr_t      dtlb_vaddr_i,
    input  ptw_pkg::ppn_t        satp_ppn_i,
    input  ptw_pkg::asid_t       asid_i,
    input  ptw_pkg::pte_t        pte_i,
    output ptw_pkg::paddr_t      pptr_o,
    output ptw_pkg::tlb_update_t itlb_update_o,
    output ptw_pkg::tlb_update_t dtlb_update_o
);
    import ptw_pkg::*;

    localparam int unsigned SLICEW = `PTW_VPN_SLICEW;

    vpn_t                 vpn_sel;
    vpn_t                 vpn_q;
    asid_t                asid_q;
    paddr_t               pptr_q;
    logic                 global_q;
    logic [SLICEW-1:0]    next_slice;
    logic [`PTW_XLEN-1:0] content_bits;
    tlb_update_t          update;

    assign vpn_sel = start_instr_i ? itlb_vaddr_i[`PTW_VLEN-1:`PTW_PGOFFW]
                                   : dtlb_vaddr_i[`PTW_VLEN-1:`PTW_PGOFFW];

    // slice that indexes the table one level down
    always_comb begin
        unique case (lvl_i)
            LVL1:    next_slice = vpn_q[2*SLICEW-1:SLICEW];
            default: next_slice = vpn_q[SLICEW-1:0];
        endcase
    end

    // root pointer from satp, then pte.ppn plus the next vpn slice
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            vpn_q  <= vpn_sel;
            asid_q <= asid_i;
            pptr_q <= {satp_ppn_i, vpn_sel[(`PTW_LEVELS-1)*SLICEW +: SLICEW],
                       {`PTW_PTE_BYTES_LOG{1'b0}}};
        end else if (descend_i) begin
            pptr_q <= {pte_i.ppn, next_slice, {`PTW_PTE_BYTES_LOG{1'b0}}};
        end
    end

    // a global pointer anywhere on the path makes the leaf global
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (start_i) begin
            global_q <= 1'b0;
        end else if (descend_i && pte_i.g) begin
            global_q <= 1'b1;
        end
    end

    assign pptr_o = pptr_q;

    // --------------------
    // tlb update
    // --------------------
    always_comb begin
        content_bits             = pte_i;
        content_bits[`PTW_PTE_G] = pte_i.g || global_q;

        update.valid   = update_valid_i;
        update.vpn     = vpn_q;
        update.asid    = asid_q;
        update.is_2m   = (lvl_i == LVL2);
        update.is_1g   = (lvl_i == LVL1);
        update.content = pte_t'(content_bits);

        itlb_update_o       = update;
        itlb_update_o.valid = update.valid && is_instr_i;
        dtlb_update_o       = update;
        dtlb_update_o.valid = update.valid && !is_instr_i;
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_ctrl.sv ====
// --------------------
// page table walk control
// arbitrates tlb misses, sequences the memory reads and decides
// update, descend or fault, draining a pending read on flush
// --------------------
`default_nettype none

module ptw_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  itlb_access_i,
    input  logic                  itlb_hit_i,
    input  logic                  dtlb_access_i,
    input  logic                  dtlb_hit_i,
    input  logic                  mem_gnt_i,
    input  logic                  pte_valid_i,
    input  ptw_pkg::pte_verdict_e verdict_i,
    output logic                  start_o,
    output logic                  start_instr_o,
    output logic                  descend_o,
    output ptw_pkg::ptw_lvl_e     lvl_o,
    output logic                  mem_req_o,
    output logic                  update_valid_o,
    output logic                  is_instr_o,
    output logic                  ptw_active_o,
    output logic                  ptw_error_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);
    import ptw_pkg::*;

    ptw_state_e state_q, state_d;
    ptw_lvl_e   lvl_q, lvl_d;
    logic       instr_q, instr_d;
    logic       dtlb_miss;
    logic       itlb_miss;

    // data side has priority when both tlbs miss together
    assign dtlb_miss = dtlb_access_i && !dtlb_hit_i;
    assign itlb_miss = itlb_access_i && !itlb_hit_i && !dtlb_miss;

    assign lvl_o        = lvl_q;
    assign is_instr_o   = instr_q;
    assign ptw_active_o = (state_q != IDLE);
    // request is held until granted, address is frozen meanwhile
    assign mem_req_o    = (state_q == WAIT_GRANT);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_d        = state_q;
        lvl_d          = lvl_q;
        instr_d        = instr_q;
        start_o        = 1'b0;
        start_instr_o  = 1'b0;
        descend_o      = 1'b0;
        update_valid_o = 1'b0;
        ptw_error_o    = 1'b0;
        itlb_miss_o    = 1'b0;
        dtlb_miss_o    = 1'b0;

        unique case (state_q)
            IDLE: begin
                // every walk starts at the root table
                lvl_d = LVL1;
                if (!flush_i && (dtlb_miss || itlb_miss)) begin
                    start_o       = 1'b1;
                    start_instr_o = itlb_miss;
                    instr_d       = itlb_miss;
                    itlb_miss_o   = itlb_miss;
                    dtlb_miss_o   = dtlb_miss;
                    state_d       = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (pte_valid_i) begin
                    unique case (verdict_i)
                        PTE_LEAF: begin
                            update_valid_o = !flush_i;
                            state_d        = IDLE;
                        end
                        PTE_POINTER: begin
                            // no table below the 4K level
                            if (lvl_q == LVL3) begin
                                state_d = PROPAGATE_ERROR;
                            end else begin
                                descend_o = 1'b1;
                                lvl_d     = (lvl_q == LVL1) ? LVL2 : LVL3;
                                state_d   = WAIT_GRANT;
                            end
                        end
                        default: begin
                            state_d = PROPAGATE_ERROR;
                        end
                    endcase
                end
            end

            PROPAGATE_ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = IDLE;
            end

            WAIT_RVALID: begin
                if (pte_valid_i) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // --------------------
        // flush
        // --------------------
        // a granted read still owes us an rvalid, so drain it first
        if (flush_i) begin
            if ((state_q == WAIT_GRANT && mem_gnt_i) ||
                ((state_q == PTE_LOOKUP || state_q == WAIT_RVALID) && !pte_valid_i)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lvl_q   <= LVL1;
            instr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            lvl_q   <= lvl_d;
            instr_q <= instr_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ptw_top.sv ====
// --------------------
// sv39 page table walker
// serves itlb and dtlb misses over a req/gnt/rvalid memory port
// --------------------
`default_nettype none

module ptw_top (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 itlb_access_i,
    input  logic                 itlb_hit_i,
    input  ptw_pkg::vaddr_t      itlb_vaddr_i,
    input  logic                 dtlb_access_i,
    input  logic                 dtlb_hit_i,
    input  ptw_pkg::vaddr_t      dtlb_vaddr_i,
    input  logic                 lsu_is_store_i,
    input  ptw_pkg::ppn_t        satp_ppn_i,
    input  ptw_pkg::asid_t       asid_i,
    input  logic                 mxr_i,
    output ptw_pkg::mem_req_t    mem_req_o,
    input  ptw_pkg::mem_rsp_t    mem_rsp_i,
    output ptw_pkg::tlb_update_t itlb_update_o,
    output ptw_pkg::tlb_update_t dtlb_update_o,
    output logic                 ptw_active_o,
    output logic                 walking_instr_o,
    output logic                 ptw_error_o,
    output logic                 itlb_miss_o,
    output logic                 dtlb_miss_o
);
    import ptw_pkg::*;

    logic         start;
    logic         start_instr;
    logic         descend;
    ptw_lvl_e     lvl;
    logic         req;
    logic         update_valid;
    logic         is_instr;
    logic         pte_valid;
    pte_verdict_e verdict;
    pte_t         pte;
    paddr_t       pptr;

    assign mem_req_o       = '{req: req, addr: pptr};
    assign walking_instr_o = is_instr;

    ptw_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .itlb_access_i  (itlb_access_i),
        .itlb_hit_i     (itlb_hit_i),
        .dtlb_access_i  (dtlb_access_i),
        .dtlb_hit_i     (dtlb_hit_i),
        .mem_gnt_i      (mem_rsp_i.gnt),
        .pte_valid_i    (pte_valid),
        .verdict_i      (verdict),
        .start_o        (start),
        .start_instr_o  (start_instr),
        .descend_o      (descend),
        .lvl_o          (lvl),
        .mem_req_o      (req),
        .update_valid_o (update_valid),
        .is_instr_o     (is_instr),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .itlb_miss_o    (itlb_miss_o),
        .dtlb_miss_o    (dtlb_miss_o)
    );

    ptw_walk_state u_walk_state (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .start_i        (start),
        .start_instr_i  (start_instr),
        .descend_i      (descend),
        .lvl_i          (lvl),
        .is_instr_i     (is_instr),
        .update_valid_i (update_valid),
        .itlb_vaddr_i   (itlb_vaddr_i),
        .dtlb_vaddr_i   (dtlb_vaddr_i),
        .satp_ppn_i     (satp_ppn_i),
        .asid_i         (asid_i),
        .pte_i          (pte),
        .pptr_o         (pptr),
        .itlb_update_o  (itlb_update_o),
        .dtlb_update_o  (dtlb_update_o)
    );

    pte_check u_pte_check (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .mem_rvalid_i (mem_rsp_i.rvalid),
        .mem_rdata_i  (mem_rsp_i.rdata),
        .lvl_i        (lvl),
        .is_instr_i   (is_instr),
        .is_store_i   (lsu_is_store_i),
        .mxr_i        (mxr_i),
        .pte_valid_o  (pte_valid),
        .pte_o        (pte),
        .verdict_o    (verdict)
    );

endmodule

`default_nettype wire

// ==== test/ptw_chk.sv ====
// --------------------
// walker port checker
// protocol assertions on the top level ports
// --------------------
`default_nettype none

module ptw_chk (
    input logic                 clk_i,
    input logic                 rst_ni,
    input ptw_pkg::mem_req_t    mem_req_o,
    input ptw_pkg::mem_rsp_t    mem_rsp_i,
    input ptw_pkg::tlb_update_t itlb_update_o,
    input ptw_pkg::tlb_update_t dtlb_update_o,
    input logic                 ptw_active_o,
    input logic                 ptw_error_o
);
    import ptw_pkg::*;

    logic upd;

    assign upd = itlb_update_o.valid || dtlb_update_o.valid;

    // memory traffic only during a walk
    req_while_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req |-> ptw_active_o)
        else $error("memory request while walker idle");

    upd_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(upd && ptw_error_o))
        else $error("update and error in the same cycle");

    upd_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        upd |=> !upd)
        else $error("update valid longer than one cycle");

    err_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptw_error_o |=> !ptw_error_o)
        else $error("error strobe longer than one cycle");

    tlb_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_update_o.valid && dtlb_update_o.valid))
        else $error("itlb and dtlb updated together");

    // address held under back-pressure
    addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.req && !mem_rsp_i.gnt) |=> $stable(mem_req_o.addr))
        else $error("address changed while waiting for grant");

endmodule

bind ptw_top ptw_chk u_chk (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .itlb_update_o (itlb_update_o),
    .dtlb_update_o (dtlb_update_o),
    .ptw_active_o  (ptw_active_o),
    .ptw_error_o   (ptw_error_o)
);

`default_nettype wire

// ==== test/ptw_tb.sv ====
// --------------------
// sv39 walker testbench
// page table memory model, walk stimulus and result checks
// --------------------
`default_nettype none

module ptw_tb;
    import ptw_pkg::*;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i = 1'b0;
    logic        itlb_access_i = 1'b0;
    logic        itlb_hit_i = 1'b0;
    vaddr_t      itlb_vaddr_i = '0;
    logic        dtlb_access_i = 1'b0;
    logic        dtlb_hit_i = 1'b0;
    vaddr_t      dtlb_vaddr_i = '0;
    logic        lsu_is_store_i = 1'b0;
    ppn_t        satp_ppn_i = 44'h100;
    asid_t       asid_i = 16'h5a;
    logic        mxr_i = 1'b0;
    mem_req_t    mem_req_o;
    mem_rsp_t    mem_rsp_i = '0;
    tlb_update_t itlb_update_o;
    tlb_update_t dtlb_update_o;
    tlb_update_t last_upd;
    logic        ptw_active_o;
    logic        walking_instr_o;
    logic        ptw_error_o;
    logic        itlb_miss_o;
    logic        dtlb_miss_o;

    logic [63:0] mem [paddr_t];
    paddr_t      addr_q[$];
    int unsigned seed = 26320;
    int          gnt_wait = 0;
    int          n_iupd, n_dupd, n_err, n_imiss, n_dmiss, n_instr, n_active;
    int          errors = 0;
    int          err_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    ptw_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) & 32'h7fff;
    endfunction

    function automatic vaddr_t make_va(input int v2, input int v1, input int v0);
        return {v2[8:0], v1[8:0], v0[8:0], 12'h000};
    endfunction

    function automatic paddr_t pte_addr(input ppn_t ppn, input int idx);
        return {ppn, idx[8:0], 3'b000};
    endfunction

    // flags are d a g u x w r v, msb first
    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return pte_t'({10'b0, ppn, 2'b00, flags});
    endfunction

    // --------------------
    // memory model
    // --------------------
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            mem_rsp_i <= '0;
        end else begin
            mem_rsp_i.rvalid <= 1'b0;
            if (mem_req_o.req && mem_rsp_i.gnt) begin
                mem_rsp_i.gnt    <= 1'b0;
                mem_rsp_i.rvalid <= 1'b1;
                mem_rsp_i.rdata  <= mem.exists(mem_req_o.addr) ? mem[mem_req_o.addr] : '0;
                gnt_wait         <= int'(next_rand() % 4);
            end else if (mem_req_o.req) begin
                if (gnt_wait == 0) begin
                    mem_rsp_i.gnt <= 1'b1;
                end else begin
                    gnt_wait <= gnt_wait - 1;
                end
            end else begin
                mem_rsp_i.gnt <= 1'b0;
            end
        end
    end

    // outputs are sampled mid cycle where they are settled
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (mem_req_o.req && mem_rsp_i.gnt) addr_q.push_back(mem_req_o.addr);
            if (itlb_update_o.valid) begin
                n_iupd++;
                last_upd = itlb_update_o;
            end
            if (dtlb_update_o.valid) begin
                n_dupd++;
                last_upd = dtlb_update_o;
            end
            if (ptw_error_o) n_err++;
            if (itlb_miss_o) n_imiss++;
            if (dtlb_miss_o) n_dmiss++;
            if (ptw_active_o && walking_instr_o) n_instr++;
            if (ptw_active_o) n_active++;
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("MISMATCH t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic start_miss(input logic instr, input vaddr_t va, input logic both);
        addr_q.delete();
        {n_iupd, n_dupd, n_err, n_imiss, n_dmiss, n_instr, n_active} = '0;
        @(posedge clk_i);
        itlb_access_i <= instr || both;
        itlb_vaddr_i  <= va;
        dtlb_access_i <= !instr || both;
        dtlb_vaddr_i  <= va;
        @(posedge clk_i);
        itlb_access_i <= 1'b0;
        dtlb_access_i <= 1'b0;
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (ptw_active_o && cyc < 50) begin
            @(negedge clk_i);
            cyc++;
        end
        if (ptw_active_o) begin
            $display("timeout: walker did not return to idle");
            errors++;
        end
    endtask

    task automatic walk(input logic instr, input vaddr_t va, input logic both);
        int cyc;
        start_miss(instr, va, both);
        cyc = 0;
        while ((n_iupd + n_dupd + n_err) == 0 && cyc < 200) begin
            @(negedge clk_i);
            cyc++;
        end
        if ((n_iupd + n_dupd + n_err) == 0) begin
            $display("timeout: walk ended with neither update nor error");
            errors++;
        end
        wait_idle();
    endtask

    task automatic set_mode(input logic store, input logic mxr);
        @(posedge clk_i);
        lsu_is_store_i <= store;
        mxr_i          <= mxr;
    endtask

    task automatic expect_update(input logic instr, input vaddr_t va, input logic is_2m,
                                 input logic is_1g, input pte_t content);
        check_count("update count", 1, instr ? n_iupd : n_dupd);
        check_count("other tlb update count", 0, instr ? n_dupd : n_iupd);
        check_count("ptw_error_o count", 0, n_err);
        check_val("update.vpn", 64'(va[38:12]), 64'(last_upd.vpn));
        check_val("update.asid", 64'(asid_i), 64'(last_upd.asid));
        check_val("update.is_2m", 64'(is_2m), 64'(last_upd.is_2m));
        check_val("update.is_1g", 64'(is_1g), 64'(last_upd.is_1g));
        check_val("update.content", 64'(content), 64'(last_upd.content));
    endtask

    task automatic expect_fault();
        check_count("ptw_error_o count", 1, n_err);
        check_count("update count", 0, n_iupd + n_dupd);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_base) tests_failed++;
        $display("test %-14s %s", name, (errors == err_base) ? "ok" : "failed");
        err_base = errors;
    endtask

    // three level 4K walk through the itlb
    task automatic itlb_4k_test(input string name);
        vaddr_t va;
        pte_t   leaf;
        va   = make_va(2, 3, 4);
        leaf = make_pte(44'h12345, 8'hcb);
        mem.delete();
        mem[pte_addr(satp_ppn_i, 2)] = make_pte(44'h200, 8'h01);
        mem[pte_addr(44'h200, 3)]    = make_pte(44'h300, 8'h01);
        mem[pte_addr(44'h300, 4)]    = leaf;
        walk(1'b1, va, 1'b0);
        check_count("read count", 3, addr_q.size());
        if (addr_q.size() == 3) begin
            check_val("mem_req_o.addr lvl1", 64'(pte_addr(satp_ppn_i, 2)), 64'(addr_q[0]));
            check_val("mem_req_o.addr lvl2", 64'(pte_addr(44'h200, 3)), 64'(addr_q[1]));
            check_val("mem_req_o.addr lvl3", 64'(pte_addr(44'h300, 4)), 64'(addr_q[2]));
        end
        expect_update(1'b1, va, 1'b0, 1'b0, leaf);
        check_count("itlb_miss_o pulses", 1, n_imiss);
        // an instruction walk is flagged for every cycle it is active
        check_count("walking_instr_o cycles", n_active, n_instr);
        end_test(name);
    endtask

    initial begin
        #(40 * 10000);
        $display("timeout: simulation watchdog expired");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        vaddr_t va;
        pte_t   leaf;
        int     cyc;
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        itlb_4k_test("itlb_4k");

        // --------------------
        // superpages
        // --------------------
        va   = make_va(1, 6, 7);
        leaf = make_pte(44'h140000, 8'hc3);
        mem.delete();
        mem[pte_addr(satp_ppn_i, 1)] = leaf;
        walk(1'b0, va, 1'b0);
        expect_update(1'b0, va, 1'b0, 1'b1, leaf);
        end_test("gigapage");

        leaf = make_pte(44'h000e00, 8'hc3);
        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h200, 8'h21);
        mem[pte_addr(44'h200, 6)]    = leaf;
        walk(1'b0, va, 1'b0);
        leaf.g = 1'b1;
        expect_update(1'b0, va, 1'b1, 1'b0, leaf);
        end_test("megapage_glob");

        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h000001, 8'hc3);
        walk(1'b0, va, 1'b0);
        expect_fault();
        end_test("misaligned");

        // --------------------
        // data permissions
        // --------------------
        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h0c0000, 8'h47);
        set_mode(1'b1, 1'b0);
        walk(1'b0, va, 1'b1);
        expect_fault();
        check_count("dtlb_miss_o pulses", 1, n_dmiss);
        check_count("itlb_miss_o pulses", 0, n_imiss);
        check_count("walking_instr_o cycles", 0, n_instr);
        end_test("store_no_d");

        leaf = make_pte(44'h0c0000, 8'h49);
        mem[pte_addr(satp_ppn_i, 1)] = leaf;
        set_mode(1'b0, 1'b0);
        walk(1'b0, va, 1'b0);
        expect_fault();
        end_test("xonly_no_mxr");

        set_mode(1'b0, 1'b1);
        walk(1'b0, va, 1'b0);
        expect_update(1'b0, va, 1'b0, 1'b1, leaf);
        set_mode(1'b0, 1'b0);
        end_test("xonly_mxr");

        // --------------------
        // faults
        // --------------------
        mem.delete();
        walk(1'b0, va, 1'b0);
        expect_fault();
        end_test("invalid_pte");

        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h0c0000, 8'h45);
        walk(1'b0, va, 1'b0);
        expect_fault();
        end_test("write_only");

        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h200, 8'h01);
        mem[pte_addr(44'h200, 6)]    = make_pte(44'h300, 8'h01);
        mem[pte_addr(44'h300, 7)]    = make_pte(44'h400, 8'h01);
        walk(1'b0, va, 1'b0);
        expect_fault();
        end_test("ptr_at_lvl3");

        mem[pte_addr(satp_ppn_i, 1)] = make_pte(44'h140000, 8'hc3);
        walk(1'b1, va, 1'b0);
        expect_fault();
        end_test("instr_no_x");

        // --------------------
        // flush with a read in flight
        // --------------------
        start_miss(1'b1, make_va(2, 3, 4), 1'b0);
        cyc = 0;
        @(negedge clk_i);
        // the grant is taken on the next rising edge
        while (!(mem_req_o.req && mem_rsp_i.gnt) && cyc < 50) begin
            @(negedge clk_i);
            cyc++;
        end
        if (!(mem_req_o.req && mem_rsp_i.gnt)) begin
            $display("timeout: no grant seen before flush");
            errors++;
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(negedge clk_i);
        check_val("ptw_active_o during flush", 64'(1), 64'(ptw_active_o));
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        check_val("ptw_active_o draining", 64'(1), 64'(ptw_active_o));
        wait_idle();
        repeat (3) @(negedge clk_i);
        check_count("update count", 0, n_iupd + n_dupd);
        check_count("ptw_error_o count", 0, n_err);
        check_count("read count", 1, addr_q.size());
        end_test("flush");

        itlb_4k_test("after_flush");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/ptw_pkg.sv
verilog/pte_check.sv
verilog/ptw_walk_state.sv
verilog/ptw_ctrl.sv
verilog/ptw_top.sv
test/ptw_chk.sv
test/ptw_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the walker testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module ptw_tb -o ptw_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/ptw_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
